//--- design/bank_arbiter.sv
`default_nettype none

module bank_arbiter
	import frame_buffer_pkg::*;
#(
	parameter bit BANK_ID = 1'b0
) (
	input logic clock,
	input logic reset,
	input logic capture_flag,
	input logic display_flag,
	input logic filter_flag,
	input logic filter_wr,
	input logic capture_bank,
	input logic display_bank,
	input logic filter_bank,
	input logic [ADDR_W-1:0] capture_address,
	input logic [ADDR_W-1:0] display_address,
	input logic [ADDR_W-1:0] filter_address,
	input logic [PIXEL_W-1:0] capture_pixel,
	input logic [PIXEL_W-1:0] filter_pixel_in,
	output logic capture_grant,
	output logic display_grant,
	output logic filter_grant,
	output logic [ADDR_W-1:0] address,
	output logic we,
	output logic [PIXEL_W-1:0] wdata,
	output client_t tag
);

	logic capture_hit;
	logic display_hit;
	logic filter_hit;
	logic [ADDR_W-1:0] next_address;
	logic [PIXEL_W-1:0] next_wdata;
	logic next_we;
	client_t next_tag;

	// requests aimed at this bank
	assign capture_hit = capture_flag && (capture_bank == BANK_ID);
	assign display_hit = display_flag && (display_bank == BANK_ID);
	assign filter_hit = filter_flag && (filter_bank == BANK_ID);

	// fixed priority capture, display, filter
	assign capture_grant = capture_hit;
	assign display_grant = display_hit && !capture_hit;
	assign filter_grant = filter_hit && !capture_hit && !display_hit;

	always_comb begin
		next_address = '0;
		next_wdata = '0;
		next_we = 1'b0;
		next_tag = CLIENT_NONE;
		if (capture_grant) begin
			next_address = capture_address;
			next_wdata = capture_pixel;
			next_we = 1'b1;
			next_tag = CLIENT_CAPTURE;
		end else if (display_grant) begin
			next_address = display_address;
			next_tag = CLIENT_DISPLAY;
		end else if (filter_grant) begin
			next_address = filter_address;
			next_wdata = filter_pixel_in;
			next_we = filter_wr;
			next_tag = filter_wr ? CLIENT_FILTER_WRITE : CLIENT_FILTER_READ;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			we <= 1'b0;
			tag <= CLIENT_NONE;
		end else begin
			we <= next_we;
			tag <= next_tag;
		end
	end

	always_ff @(posedge clock) begin
		address <= next_address;
		wdata <= next_wdata;
	end

endmodule

`default_nettype wire

//--- design/buffer_rotation.sv
`default_nettype none

module buffer_rotation
	import frame_buffer_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic frame_flag,
	output logic capture_bank,
	output logic [SLOT_W-1:0] capture_slot,
	output logic display_bank,
	output logic [SLOT_W-1:0] display_slot,
	output logic filter_bank,
	output logic [SLOT_W-1:0] filter_slot
);

	// next-display role is not visible to any client
	logic next_display_bank;
	logic [SLOT_W-1:0] next_display_slot;

	always_ff @(posedge clock) begin
		if (reset) begin
			capture_bank <= CAPTURE_RESET_BANK;
			capture_slot <= CAPTURE_RESET_SLOT;
			filter_bank <= PROCESS_RESET_BANK;
			filter_slot <= PROCESS_RESET_SLOT;
			next_display_bank <= NEXT_DISPLAY_RESET_BANK;
			next_display_slot <= NEXT_DISPLAY_RESET_SLOT;
			display_bank <= DISPLAY_RESET_BANK;
			display_slot <= DISPLAY_RESET_SLOT;
		end else if (frame_flag) begin
			// capture reuses the frame the filter is done with
			capture_bank <= filter_bank;
			capture_slot <= filter_slot;
			// filter picks up the frame just shown
			filter_bank <= display_bank;
			filter_slot <= display_slot;
			// freshly captured frame waits one period before display
			next_display_bank <= capture_bank;
			next_display_slot <= capture_slot;
			display_bank <= next_display_bank;
			display_slot <= next_display_slot;
		end
	end

endmodule

`default_nettype wire

//--- design/frame_buffer_pkg.sv
`default_nettype none

package frame_buffer_pkg;

	// memory word and address widths
	localparam int PIXEL_W = 36;
	localparam int ADDR_W = 19;

	// coordinate and slot widths
	localparam int X_W = 10;
	localparam int Y_W = 9;
	localparam int SLOT_W = 2;

	// frame geometry, two pixels per word
	localparam int IMAGE_WIDTH = 640;
	localparam int IMAGE_HEIGHT = 480;
	localparam int HALF_WIDTH = IMAGE_WIDTH / 2;
	localparam int FRAME_WORDS = HALF_WIDTH * IMAGE_HEIGHT;

	// owner of a bank cycle
	typedef enum logic [2:0] {
		CLIENT_NONE = 3'd0,
		CLIENT_CAPTURE = 3'd1,
		CLIENT_DISPLAY = 3'd2,
		CLIENT_FILTER_READ = 3'd3,
		CLIENT_FILTER_WRITE = 3'd4
	} client_t;

	// role placement after reset
	localparam logic CAPTURE_RESET_BANK = 1'b0;
	localparam logic [SLOT_W-1:0] CAPTURE_RESET_SLOT = 2'd0;
	localparam logic PROCESS_RESET_BANK = 1'b0;
	localparam logic [SLOT_W-1:0] PROCESS_RESET_SLOT = 2'd1;
	localparam logic NEXT_DISPLAY_RESET_BANK = 1'b1;
	localparam logic [SLOT_W-1:0] NEXT_DISPLAY_RESET_SLOT = 2'd0;
	localparam logic DISPLAY_RESET_BANK = 1'b1;
	localparam logic [SLOT_W-1:0] DISPLAY_RESET_SLOT = 2'd1;

endpackage

`default_nettype wire

//--- design/frame_buffer_top.sv
`default_nettype none

module frame_buffer_top
	import frame_buffer_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic frame_flag,
	input logic capture_flag,
	input logic [X_W-1:0] capture_x,
	input logic [Y_W-1:0] capture_y,
	input logic [PIXEL_W-1:0] capture_pixel,
	input logic display_flag,
	input logic [X_W-1:0] display_x,
	input logic [Y_W-1:0] display_y,
	input logic filter_flag,
	input logic filter_wr,
	input logic [X_W-1:0] filter_x,
	input logic [Y_W-1:0] filter_y,
	input logic [PIXEL_W-1:0] filter_pixel_in,
	output logic capture_done,
	output logic display_done,
	output logic filter_done,
	output logic [PIXEL_W-1:0] display_pixel,
	output logic [PIXEL_W-1:0] filter_pixel,
	output logic [ADDR_W-1:0] ram0_address,
	output logic ram0_we,
	output logic [PIXEL_W-1:0] ram0_wdata,
	input logic [PIXEL_W-1:0] ram0_rdata,
	output logic [ADDR_W-1:0] ram1_address,
	output logic ram1_we,
	output logic [PIXEL_W-1:0] ram1_wdata,
	input logic [PIXEL_W-1:0] ram1_rdata
);

	logic capture_bank, display_bank, filter_bank;
	logic [SLOT_W-1:0] capture_slot, display_slot, filter_slot;
	logic [ADDR_W-1:0] capture_address, display_address, filter_address;

	logic capture_grant0, display_grant0, filter_grant0;
	logic capture_grant1, display_grant1, filter_grant1;
	logic [ADDR_W-1:0] address0, address1;
	logic we0, we1;
	logic [PIXEL_W-1:0] wdata0, wdata1;
	client_t tag0, tag1;

	buffer_rotation i_rotation (
		.clock(clock), .reset(reset), .frame_flag(frame_flag),
		.capture_bank(capture_bank), .capture_slot(capture_slot),
		.display_bank(display_bank), .display_slot(display_slot),
		.filter_bank(filter_bank), .filter_slot(filter_slot)
	);

	pixel_address i_capture_address (
		.x(capture_x), .y(capture_y), .slot(capture_slot), .address(capture_address)
	);
	pixel_address i_display_address (
		.x(display_x), .y(display_y), .slot(display_slot), .address(display_address)
	);
	pixel_address i_filter_address (
		.x(filter_x), .y(filter_y), .slot(filter_slot), .address(filter_address)
	);

	bank_arbiter #(.BANK_ID(1'b0)) i_arbiter0 (
		.clock(clock), .reset(reset),
		.capture_flag(capture_flag), .display_flag(display_flag),
		.filter_flag(filter_flag), .filter_wr(filter_wr),
		.capture_bank(capture_bank), .display_bank(display_bank), .filter_bank(filter_bank),
		.capture_address(capture_address), .display_address(display_address),
		.filter_address(filter_address),
		.capture_pixel(capture_pixel), .filter_pixel_in(filter_pixel_in),
		.capture_grant(capture_grant0), .display_grant(display_grant0),
		.filter_grant(filter_grant0),
		.address(address0), .we(we0), .wdata(wdata0), .tag(tag0)
	);

	bank_arbiter #(.BANK_ID(1'b1)) i_arbiter1 (
		.clock(clock), .reset(reset),
		.capture_flag(capture_flag), .display_flag(display_flag),
		.filter_flag(filter_flag), .filter_wr(filter_wr),
		.capture_bank(capture_bank), .display_bank(display_bank), .filter_bank(filter_bank),
		.capture_address(capture_address), .display_address(display_address),
		.filter_address(filter_address),
		.capture_pixel(capture_pixel), .filter_pixel_in(filter_pixel_in),
		.capture_grant(capture_grant1), .display_grant(display_grant1),
		.filter_grant(filter_grant1),
		.address(address1), .we(we1), .wdata(wdata1), .tag(tag1)
	);

	// a client is served by whichever bank holds its role
	assign capture_done = capture_grant0 | capture_grant1;
	assign display_done = display_grant0 | display_grant1;
	assign filter_done = filter_grant0 | filter_grant1;

	read_return i_read_return (
		.clock(clock), .reset(reset),
		.bank0_tag(tag0), .bank1_tag(tag1),
		.ram0_rdata(ram0_rdata), .ram1_rdata(ram1_rdata),
		.display_pixel(display_pixel), .filter_pixel(filter_pixel)
	);

	ram_port i_ram_port0 (
		.clock(clock), .reset(reset),
		.address(address0), .we(we0), .wdata(wdata0),
		.ram_address(ram0_address), .ram_we(ram0_we), .ram_wdata(ram0_wdata)
	);

	ram_port i_ram_port1 (
		.clock(clock), .reset(reset),
		.address(address1), .we(we1), .wdata(wdata1),
		.ram_address(ram1_address), .ram_we(ram1_we), .ram_wdata(ram1_wdata)
	);

endmodule

`default_nettype wire

//--- design/pixel_address.sv
`default_nettype none

module pixel_address
	import frame_buffer_pkg::*;
(
	input logic [X_W-1:0] x,
	input logic [Y_W-1:0] y,
	input logic [SLOT_W-1:0] slot,
	output logic [ADDR_W-1:0] address
);

	logic [ADDR_W-1:0] line_address;
	logic [ADDR_W-1:0] frame_base;

	// start of line plus word within the line
	assign line_address = ADDR_W'(y) * ADDR_W'(HALF_WIDTH) + ADDR_W'(x[X_W-1:1]);

	// slots are laid out back to back in a bank
	assign frame_base = ADDR_W'(slot) * ADDR_W'(FRAME_WORDS);

	assign address = line_address + frame_base;

endmodule

`default_nettype wire

//--- design/ram_port.sv
`default_nettype none

module ram_port
	import frame_buffer_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic [ADDR_W-1:0] address,
	input logic we,
	input logic [PIXEL_W-1:0] wdata,
	output logic [ADDR_W-1:0] ram_address,
	output logic ram_we,
	output logic [PIXEL_W-1:0] ram_wdata
);

	logic [PIXEL_W-1:0] data_d1;
	logic [PIXEL_W-1:0] data_d2;
	// marks which delayed data word belongs to a write
	logic [1:0] write_pending;

	// command goes to the SRAM as is
	assign ram_address = address;
	assign ram_we = we;

	always_ff @(posedge clock) begin
		data_d1 <= wdata;
		data_d2 <= data_d1;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			write_pending <= '0;
		end else begin
			write_pending <= {write_pending[0], we};
		end
	end

	// data bus idles at zero outside the write data slot
	assign ram_wdata = write_pending[1] ? data_d2 : '0;

endmodule

`default_nettype wire

//--- design/read_return.sv
`default_nettype none

module read_return
	import frame_buffer_pkg::*;
(
	input logic clock,
	input logic reset,
	input client_t bank0_tag,
	input client_t bank1_tag,
	input logic [PIXEL_W-1:0] ram0_rdata,
	input logic [PIXEL_W-1:0] ram1_rdata,
	output logic [PIXEL_W-1:0] display_pixel,
	output logic [PIXEL_W-1:0] filter_pixel
);

	localparam int STAGES = 3;

	// per bank tag delay, last stage lines up with the read data
	client_t tag_pipe [2][STAGES];
	logic [PIXEL_W-1:0] display_hold;
	logic [PIXEL_W-1:0] filter_hold;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int b = 0; b < 2; b++) begin
				for (int s = 0; s < STAGES; s++) begin
					tag_pipe[b][s] <= CLIENT_NONE;
				end
			end
		end else begin
			tag_pipe[0][0] <= bank0_tag;
			tag_pipe[1][0] <= bank1_tag;
			for (int b = 0; b < 2; b++) begin
				for (int s = 1; s < STAGES; s++) begin
					tag_pipe[b][s] <= tag_pipe[b][s-1];
				end
			end
		end
	end

	// returning word goes straight out, else the last one is held
	always_comb begin
		display_pixel = display_hold;
		filter_pixel = filter_hold;
		if (tag_pipe[0][STAGES-1] == CLIENT_DISPLAY) begin
			display_pixel = ram0_rdata;
		end else if (tag_pipe[1][STAGES-1] == CLIENT_DISPLAY) begin
			display_pixel = ram1_rdata;
		end
		if (tag_pipe[0][STAGES-1] == CLIENT_FILTER_READ) begin
			filter_pixel = ram0_rdata;
		end else if (tag_pipe[1][STAGES-1] == CLIENT_FILTER_READ) begin
			filter_pixel = ram1_rdata;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			display_hold <= '0;
			filter_hold <= '0;
		end else begin
			display_hold <= display_pixel;
			filter_hold <= filter_pixel;
		end
	end

endmodule

`default_nettype wire

//--- dv/clock_gen.sv
`default_nettype none

module clock_gen (
	output logic clock,
	output logic reset
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int HALF_PERIOD = 20;
	localparam int RESET_CYCLES = 16;

	initial begin
		clock = 1'b0;
		forever #(HALF_PERIOD) clock = ~clock;
	end

	// reset released on a rising edge, like any other input
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

//--- dv/frame_buffer_checker.sv
`default_nettype none

module frame_buffer_checker (
	input logic clock,
	input logic reset,
	input logic capture_flag,
	input logic display_flag,
	input logic filter_flag,
	input logic capture_done,
	input logic display_done,
	input logic filter_done,
	input logic ram0_we,
	input logic ram1_we,
	input logic display_grant0,
	input logic display_grant1
);

	timeunit 1ns;
	timeprecision 1ps;

	// a done only answers a pending request
	capture_done_has_flag: assert property (@(posedge clock) capture_done |-> capture_flag)
		else $error("capture_done is high while capture_flag is low");
	display_done_has_flag: assert property (@(posedge clock) display_done |-> display_flag)
		else $error("display_done is high while display_flag is low");
	filter_done_has_flag: assert property (@(posedge clock) filter_done |-> filter_flag)
		else $error("filter_done is high while filter_flag is low");

	// write enables clear on the first reset edge
	no_write_in_reset: assert property (@(posedge clock)
		reset && $past(reset) |-> !ram0_we && !ram1_we)
		else $error("a bank write enable is high during reset");

	// display only ever reads
	display_read_bank0: assert property (@(posedge clock) disable iff (reset)
		display_grant0 |=> !ram0_we)
		else $error("bank 0 wrote for a display grant");
	display_read_bank1: assert property (@(posedge clock) disable iff (reset)
		display_grant1 |=> !ram1_we)
		else $error("bank 1 wrote for a display grant");

endmodule

bind frame_buffer_top frame_buffer_checker i_checker (
	.clock(clock), .reset(reset),
	.capture_flag(capture_flag), .display_flag(display_flag), .filter_flag(filter_flag),
	.capture_done(capture_done), .display_done(display_done), .filter_done(filter_done),
	.ram0_we(ram0_we), .ram1_we(ram1_we),
	.display_grant0(display_grant0), .display_grant1(display_grant1)
);

`default_nettype wire

//--- dv/frame_buffer_tb.sv
`default_nettype none

module frame_buffer_tb
	import frame_buffer_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLOCK_PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	localparam int FRAME_CYCLES = 200;
	localparam int FRAMES = 8;
	localparam int TEST_CYCLES = FRAMES * FRAME_CYCLES;
	localparam int TIMEOUT = (TEST_CYCLES + RESET_CYCLES + 50) * CLOCK_PERIOD;

	// role index into the model tables
	localparam int ROLE_CAPTURE = 0;
	localparam int ROLE_PROCESS = 1;
	localparam int ROLE_NEXT = 2;
	localparam int ROLE_DISPLAY = 3;

	logic clock, reset, frame_flag;
	logic capture_flag, display_flag, filter_flag, filter_wr;
	logic [X_W-1:0] capture_x, display_x, filter_x;
	logic [Y_W-1:0] capture_y, display_y, filter_y;
	logic [PIXEL_W-1:0] capture_pixel, filter_pixel_in;
	logic capture_done, display_done, filter_done;
	logic [PIXEL_W-1:0] display_pixel, filter_pixel;
	logic [ADDR_W-1:0] ram0_address, ram1_address;
	logic ram0_we, ram1_we;
	logic [PIXEL_W-1:0] ram0_wdata, ram1_wdata, ram0_rdata, ram1_rdata;

	// reference memory keyed by bank and word address
	logic [PIXEL_W-1:0] model_mem [logic [ADDR_W:0]];
	logic role_bank [4];
	logic [SLOT_W-1:0] role_slot [4];
	// per bank command history, entry 0 granted at the last edge
	client_t hist_tag [2][4];
	logic [ADDR_W-1:0] hist_address [2][4];
	logic [PIXEL_W-1:0] hist_word [2][4];
	logic [PIXEL_W-1:0] expect_display, expect_filter;
	logic capture_taken, display_taken, filter_taken;
	int capture_gap, display_gap, filter_gap;
	logic [X_W-1:0] written_x;
	logic [Y_W-1:0] written_y;
	int errors, checks;

	clock_gen i_clock_gen (.clock(clock), .reset(reset));

	frame_buffer_top i_dut (.*);

	zbt_sram_model #(.BANK_ID(1'b0)) i_ram0 (
		.clock(clock), .address(ram0_address), .we(ram0_we),
		.wdata(ram0_wdata), .rdata(ram0_rdata)
	);

	zbt_sram_model #(.BANK_ID(1'b1)) i_ram1 (
		.clock(clock), .address(ram1_address), .we(ram1_we),
		.wdata(ram1_wdata), .rdata(ram1_rdata)
	);

	// two pixels per word, slots back to back
	function automatic logic [ADDR_W-1:0] word_address(logic [X_W-1:0] x, logic [Y_W-1:0] y,
			logic [SLOT_W-1:0] slot);
		int unsigned a;
		a = int'(y) * HALF_WIDTH + int'(x) / 2 + int'(slot) * FRAME_WORDS;
		return ADDR_W'(a);
	endfunction

	// power-up contents of the SRAM banks
	function automatic logic [PIXEL_W-1:0] fill_word(logic bank, logic [ADDR_W-1:0] a);
		return {bank, a, a[15:0] ^ 16'h5a3c};
	endfunction

	function automatic logic [PIXEL_W-1:0] random_word();
		return PIXEL_W'({$urandom(), $urandom()});
	endfunction

	function automatic logic writes(client_t tag);
		return tag == CLIENT_CAPTURE || tag == CLIENT_FILTER_WRITE;
	endfunction

	task automatic compare(string name, logic [63:0] actual, logic [63:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("mismatch %s: got %h, expected %h at %0t", name, actual, expected, $time);
		end
	endtask

	task automatic reset_model();
		role_bank[ROLE_CAPTURE] = CAPTURE_RESET_BANK;
		role_slot[ROLE_CAPTURE] = CAPTURE_RESET_SLOT;
		role_bank[ROLE_PROCESS] = PROCESS_RESET_BANK;
		role_slot[ROLE_PROCESS] = PROCESS_RESET_SLOT;
		role_bank[ROLE_NEXT] = NEXT_DISPLAY_RESET_BANK;
		role_slot[ROLE_NEXT] = NEXT_DISPLAY_RESET_SLOT;
		role_bank[ROLE_DISPLAY] = DISPLAY_RESET_BANK;
		role_slot[ROLE_DISPLAY] = DISPLAY_RESET_SLOT;
		for (int b = 0; b < 2; b++) begin
			for (int s = 0; s < 4; s++) begin
				hist_tag[b][s] = CLIENT_NONE;
				hist_address[b][s] = '0;
				hist_word[b][s] = '0;
			end
		end
		expect_display = '0;
		expect_filter = '0;
	endtask

	// bank pins and returned pixels against earlier grants
	task automatic check_outputs();
		logic bank_we;
		logic [ADDR_W-1:0] bank_address;
		logic [PIXEL_W-1:0] bank_wdata;
		for (int b = 0; b < 2; b++) begin
			bank_we = b == 0 ? ram0_we : ram1_we;
			bank_address = b == 0 ? ram0_address : ram1_address;
			bank_wdata = b == 0 ? ram0_wdata : ram1_wdata;
			compare($sformatf("ram%0d_we", b), 64'(bank_we), 64'(writes(hist_tag[b][0])));
			if (hist_tag[b][0] != CLIENT_NONE) begin
				compare($sformatf("ram%0d_address", b), 64'(bank_address),
					64'(hist_address[b][0]));
			end
			if (writes(hist_tag[b][2])) begin
				compare($sformatf("ram%0d_wdata", b), 64'(bank_wdata), 64'(hist_word[b][2]));
			end
			if (hist_tag[b][3] == CLIENT_DISPLAY) begin
				expect_display = hist_word[b][3];
			end
			if (hist_tag[b][3] == CLIENT_FILTER_READ) begin
				expect_filter = hist_word[b][3];
			end
		end
		compare("display_pixel", 64'(display_pixel), 64'(expect_display));
		compare("filter_pixel", 64'(filter_pixel), 64'(expect_filter));
	endtask

	// grants for the coming edge, then memory update and rotation
	task automatic model_grants();
		logic bank, keep_bank;
		logic [SLOT_W-1:0] keep_slot;
		logic grant_capture, grant_display, grant_filter;
		client_t tag;
		logic [ADDR_W-1:0] address;
		logic [PIXEL_W-1:0] word;
		grant_capture = 1'b0;
		grant_display = 1'b0;
		grant_filter = 1'b0;
		for (int b = 0; b < 2; b++) begin
			bank = 1'(b);
			tag = CLIENT_NONE;
			address = '0;
			word = '0;
			if (capture_flag && role_bank[ROLE_CAPTURE] == bank) begin
				tag = CLIENT_CAPTURE;
				address = word_address(capture_x, capture_y, role_slot[ROLE_CAPTURE]);
				word = capture_pixel;
				grant_capture = 1'b1;
			end else if (display_flag && role_bank[ROLE_DISPLAY] == bank) begin
				tag = CLIENT_DISPLAY;
				address = word_address(display_x, display_y, role_slot[ROLE_DISPLAY]);
				grant_display = 1'b1;
			end else if (filter_flag && role_bank[ROLE_PROCESS] == bank) begin
				tag = filter_wr ? CLIENT_FILTER_WRITE : CLIENT_FILTER_READ;
				address = word_address(filter_x, filter_y, role_slot[ROLE_PROCESS]);
				word = filter_pixel_in;
				grant_filter = 1'b1;
			end
			if (writes(tag)) begin
				model_mem[{bank, address}] = word;
			end else if (tag != CLIENT_NONE) begin
				word = model_mem.exists({bank, address}) ? model_mem[{bank, address}]
					: fill_word(bank, address);
			end
			for (int s = 3; s > 0; s--) begin
				hist_tag[b][s] = hist_tag[b][s-1];
				hist_address[b][s] = hist_address[b][s-1];
				hist_word[b][s] = hist_word[b][s-1];
			end
			hist_tag[b][0] = tag;
			hist_address[b][0] = address;
			hist_word[b][0] = word;
		end
		compare("capture_done", 64'(capture_done), 64'(grant_capture));
		compare("display_done", 64'(display_done), 64'(grant_display));
		compare("filter_done", 64'(filter_done), 64'(grant_filter));
		capture_taken = capture_done;
		display_taken = display_done;
		filter_taken = filter_done;
		if (frame_flag) begin
			keep_bank = role_bank[ROLE_CAPTURE];
			keep_slot = role_slot[ROLE_CAPTURE];
			role_bank[ROLE_CAPTURE] = role_bank[ROLE_PROCESS];
			role_slot[ROLE_CAPTURE] = role_slot[ROLE_PROCESS];
			role_bank[ROLE_PROCESS] = role_bank[ROLE_DISPLAY];
			role_slot[ROLE_PROCESS] = role_slot[ROLE_DISPLAY];
			role_bank[ROLE_DISPLAY] = role_bank[ROLE_NEXT];
			role_slot[ROLE_DISPLAY] = role_slot[ROLE_NEXT];
			role_bank[ROLE_NEXT] = keep_bank;
			role_slot[ROLE_NEXT] = keep_slot;
		end
	endtask

	// a request stays up until done, the next one follows a random gap
	task automatic drive_inputs(int cycle);
		logic write;
		logic [X_W-1:0] x;
		logic [Y_W-1:0] y;
		frame_flag <= (cycle % FRAME_CYCLES) == FRAME_CYCLES - 1;
		if (capture_taken || !capture_flag) begin
			if (capture_gap == 0) begin
				capture_flag <= 1'b1;
				capture_x <= X_W'($urandom_range(31, 0));
				capture_y <= Y_W'($urandom_range(7, 0));
				capture_pixel <= random_word();
				capture_gap = $urandom_range(3, 0);
			end else begin
				capture_flag <= 1'b0;
				capture_gap--;
			end
		end
		if (display_taken || !display_flag) begin
			if (display_gap == 0) begin
				display_flag <= 1'b1;
				display_x <= X_W'($urandom_range(31, 0));
				display_y <= Y_W'($urandom_range(7, 0));
				display_gap = $urandom_range(3, 0);
			end else begin
				display_flag <= 1'b0;
				display_gap--;
			end
		end
		if (filter_taken || !filter_flag) begin
			if (filter_gap == 0) begin
				write = $urandom_range(1, 0) == 1;
				x = X_W'($urandom_range(31, 0));
				y = Y_W'($urandom_range(7, 0));
				// half the reads go back to the last written pixel
				if (!write && $urandom_range(1, 0) == 1) begin
					x = written_x;
					y = written_y;
				end
				if (write) begin
					written_x = x;
					written_y = y;
				end
				filter_flag <= 1'b1;
				filter_wr <= write;
				filter_x <= x;
				filter_y <= y;
				filter_pixel_in <= random_word();
				filter_gap = $urandom_range(3, 0);
			end else begin
				filter_flag <= 1'b0;
				filter_gap--;
			end
		end
	endtask

	initial begin
		errors = 0;
		checks = 0;
		capture_gap = 0;
		display_gap = 0;
		filter_gap = 0;
		capture_taken = 1'b0;
		display_taken = 1'b0;
		filter_taken = 1'b0;
		written_x = '0;
		written_y = '0;
		void'($urandom(93006));
		frame_flag = 1'b0;
		capture_flag = 1'b0;
		capture_x = '0;
		capture_y = '0;
		capture_pixel = '0;
		display_flag = 1'b0;
		display_x = '0;
		display_y = '0;
		filter_flag = 1'b0;
		filter_wr = 1'b0;
		filter_x = '0;
		filter_y = '0;
		filter_pixel_in = '0;
		reset_model();
		@(negedge reset);
		for (int cycle = 0; cycle < TEST_CYCLES; cycle++) begin
			@(negedge clock);
			check_outputs();
			model_grants();
			@(posedge clock);
			drive_inputs(cycle);
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT);
		$display("timeout after %0d ns, the test loop did not finish", TIMEOUT);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/zbt_sram_model.sv
`default_nettype none

module zbt_sram_model
	import frame_buffer_pkg::*;
#(
	parameter bit BANK_ID = 1'b0
) (
	input logic clock,
	input logic [ADDR_W-1:0] address,
	input logic we,
	input logic [PIXEL_W-1:0] wdata,
	output logic [PIXEL_W-1:0] rdata
);

	timeunit 1ns;
	timeprecision 1ps;

	// sparse storage, only written words are kept
	logic [PIXEL_W-1:0] mem [logic [ADDR_W-1:0]];
	logic [ADDR_W-1:0] address_d1;
	logic [ADDR_W-1:0] address_d2;
	logic we_d1;
	logic we_d2;

	// power-up contents built from bank and full address
	function automatic logic [PIXEL_W-1:0] fill_word(logic [ADDR_W-1:0] a);
		return {BANK_ID, a, a[15:0] ^ 16'h5a3c};
	endfunction

	always @(posedge clock) begin
		address_d1 <= address;
		we_d1 <= we;
		address_d2 <= address_d1;
		we_d2 <= we_d1;
		// late write, data follows its address by two edges
		if (we_d2) begin
			mem[address_d2] = wdata;
		end
		rdata <= mem.exists(address_d2) ? mem[address_d2] : fill_word(address_d2);
	end

endmodule

`default_nettype wire

//--- frame_buffer_top.f
design/frame_buffer_pkg.sv
design/pixel_address.sv
design/buffer_rotation.sv
design/bank_arbiter.sv
design/ram_port.sv
design/read_return.sv
design/frame_buffer_top.sv
dv/clock_gen.sv
dv/zbt_sram_model.sv
dv/frame_buffer_checker.sv
dv/frame_buffer_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module frame_buffer_tb -f frame_buffer_top.f -o frame_buffer_sim &&
{ sim_output=$(./obj_dir/frame_buffer_sim); printf '%s\n' "$sim_output"; } &&
printf '%s\n' "$sim_output" | grep -qx "NO ERRORS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
